// File: verilog/cache_pkg.sv
// shared geometry and types; 4 ways of 64 sets, 16-byte lines, aligned accesses only
package cache_pkg;

    localparam int addr_w     = 32;
    localparam int line_bytes = 16;
    localparam int line_w     = line_bytes * 8;
    localparam int num_sets   = 64;
    localparam int num_ways   = 4;
    localparam int index_w    = 6;
    localparam int offset_w   = 4;
    localparam int tag_w      = addr_w - index_w - offset_w;

    // access size, encoding kept from the processor side
    typedef enum logic [1:0] {
        sz_word = 2'd0,
        sz_byte = 2'd1,
        sz_half = 2'd2
    } size_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_respond
    } ctrl_state_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] wdata;
        size_t             size;
        logic              we;
    } cpu_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;   // line aligned
        logic              we;
        logic [line_w-1:0] wline;
    } mem_req_t;

    // controller to ways, one enable bit per way
    typedef struct packed {
        logic [num_ways-1:0] write_en;
        logic [num_ways-1:0] load_en;
        logic [addr_w-1:0]   addr;
        logic [line_w-1:0]   load_line;
        logic [addr_w-1:0]   wdata;
        size_t               size;
    } way_cmd_t;

endpackage

// File: verilog/cache_way.sv
// one cache way; offsets must be aligned to the access size, load wins over write
`timescale 1ns/100ps

module cache_way import cache_pkg::*; #(
    parameter int way_id = 0
) (
    input  logic              clk,
    input  logic              rst,
    input  way_cmd_t          cmd,
    output logic              hit,
    output logic              valid,
    output logic              dirty,
    output logic [tag_w-1:0]  tag_out,
    output logic [line_w-1:0] line_out,
    output logic [31:0]       rdata
);

    logic [tag_w-1:0]    tag_mem  [num_sets];
    logic [line_w-1:0]   line_mem [num_sets];
    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;

    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;
    logic [tag_w-1:0]    tag_in;
    logic [6:0]          bit_off;
    logic [line_w-1:0]   shifted;

    assign index   = cmd.addr[offset_w +: index_w];
    assign offset  = cmd.addr[offset_w-1:0];
    assign tag_in  = cmd.addr[addr_w-1 -: tag_w];
    assign bit_off = {offset, 3'b000};

    assign valid    = valid_bits[index];
    assign dirty    = dirty_bits[index];
    assign tag_out  = tag_mem[index];
    assign line_out = line_mem[index];
    assign hit      = valid && (tag_out == tag_in);

    // bring the addressed bytes down to bit 0, then zero-extend
    assign shifted = line_out >> bit_off;

    always_comb begin
        case (cmd.size)
            sz_byte: rdata = {24'd0, shifted[7:0]};
            sz_half: rdata = {16'd0, shifted[15:0]};
            default: rdata = shifted[31:0];
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (cmd.load_en[way_id]) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;   // fresh copy from memory
        end else if (cmd.write_en[way_id]) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.load_en[way_id]) begin
            line_mem[index] <= cmd.load_line;
            tag_mem[index]  <= tag_in;
        end else if (cmd.write_en[way_id]) begin
            case (cmd.size)
                sz_byte: line_mem[index][bit_off +: 8]  <= cmd.wdata[7:0];
                sz_half: line_mem[index][bit_off +: 16] <= cmd.wdata[15:0];
                default: line_mem[index][bit_off +: 32] <= cmd.wdata;
            endcase
        end
    end

endmodule

// File: verilog/plru_tree.sv
// tree pseudo-LRU for 4 ways; one touch per cycle, victim is read combinationally
`timescale 1ns/100ps

module plru_tree import cache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [index_w-1:0] index,
    input  logic               touch,
    input  logic [1:0]         touch_way,
    output logic [1:0]         victim
);

    // bit 0 is the root, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    // a set bit points to the right (higher) side
    logic [2:0] tree_bits [num_sets];
    logic [2:0] node;

    assign node = tree_bits[index];

    // walk down from the root
    always_comb begin
        if (node[0]) begin
            victim = {1'b1, node[2]};
        end else begin
            victim = {1'b0, node[1]};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_bits[s] <= '0;
            end
        end else if (touch) begin
            tree_bits[index][0] <= ~touch_way[1];  // root away from touched half
            if (touch_way[1]) begin
                tree_bits[index][2] <= ~touch_way[0];
            end else begin
                tree_bits[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

// File: verilog/cache_ctrl.sv
// miss FSM; one access at a time, req only accepted while idle, hit done two cycles after req
`timescale 1ns/100ps

module cache_ctrl import cache_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  cpu_req_t            req_data,
    input  logic                hit,
    input  logic [1:0]          hit_way,
    input  logic [31:0]         hit_rdata,
    input  logic [num_ways-1:0] valid_vec,
    input  logic                victim_dirty,
    input  logic [tag_w-1:0]    victim_tag,
    input  logic [line_w-1:0]   victim_line,
    input  logic [1:0]          plru_victim,
    input  logic                mem_ack,
    input  logic [line_w-1:0]   mem_rline,
    output way_cmd_t            cmd,
    output logic                touch,
    output logic [1:0]          touch_way,
    output logic [1:0]          fill_way,
    output logic                mem_req,
    output mem_req_t            mem_cmd,
    output logic                done,
    output logic                busy,
    output logic [31:0]         rdata
);

    ctrl_state_t state;
    cpu_req_t    req_q;
    logic [1:0]  fill_choice;
    logic [1:0]  fill_way_q;
    logic        refill_ack;
    mem_req_t    wb_cmd;
    mem_req_t    rd_cmd;

    // first invalid way wins, else the tree victim
    always_comb begin
        fill_choice = plru_victim;
        for (int i = num_ways - 1; i >= 0; i--) begin
            if (!valid_vec[i]) fill_choice = 2'(i);
        end
    end

    assign fill_way   = (state == st_lookup) ? fill_choice : fill_way_q;
    assign refill_ack = (state == st_refill) && mem_req && mem_ack;

    assign wb_cmd = '{addr: {victim_tag, req_q.addr[offset_w +: index_w], {offset_w{1'b0}}},
                      we: 1'b1, wline: victim_line};
    assign rd_cmd = '{addr: {req_q.addr[addr_w-1:offset_w], {offset_w{1'b0}}},
                      we: 1'b0, wline: '0};

    always_comb begin
        cmd           = '0;
        cmd.addr      = req_q.addr;
        cmd.load_line = mem_rline;
        cmd.wdata     = req_q.wdata;
        cmd.size      = req_q.size;
        if (state == st_lookup && hit && req_q.we) cmd.write_en[hit_way] = 1'b1;
        if (refill_ack) cmd.load_en[fill_way_q] = 1'b1;
    end

    assign touch     = (state == st_lookup && hit) || refill_ack;
    assign touch_way = refill_ack ? fill_way_q : hit_way;
    assign done      = (state == st_respond);
    assign busy      = (state != st_idle);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= st_idle;
            mem_req <= 1'b0;
        end else begin
            case (state)
                st_idle: if (req) state <= st_lookup;
                st_lookup: begin
                    if (hit) begin
                        state <= st_respond;
                    end else begin
                        mem_req <= 1'b1;   // write-back first if the victim is dirty
                        state   <= victim_dirty ? st_writeback : st_refill;
                    end
                end
                st_writeback: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= st_refill;
                    end
                end
                st_refill: begin
                    if (!mem_req) begin
                        mem_req <= 1'b1;   // read issued one cycle after write-back
                    end else if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= st_lookup;  // retry, now hits
                    end
                end
                st_respond: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) req_q <= req_data;
        if (state == st_lookup && hit) rdata <= hit_rdata;
        if (state == st_lookup && !hit) begin
            fill_way_q <= fill_choice;
            mem_cmd    <= victim_dirty ? wb_cmd : rd_cmd;
        end
        if (state == st_refill && !mem_req) mem_cmd <= rd_cmd;
    end

endmodule

// File: verilog/dcache_top.sv
// 4-way write-back data cache top; aligned accesses, single outstanding miss
`timescale 1ns/100ps

module dcache_top import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  cpu_req_t          req_data,
    output logic              done,
    output logic              busy,
    output logic [31:0]       rdata,
    output logic              mem_req,
    output mem_req_t          mem_cmd,
    input  logic              mem_ack,
    input  logic [line_w-1:0] mem_rline
);

    way_cmd_t            cmd;
    logic [num_ways-1:0] hit_vec;
    logic [num_ways-1:0] valid_vec;
    logic [num_ways-1:0] dirty_vec;
    logic [tag_w-1:0]    tag_arr   [num_ways];
    logic [line_w-1:0]   line_arr  [num_ways];
    logic [31:0]         rdata_arr [num_ways];

    logic       hit;
    logic [1:0] hit_way;
    logic [1:0] fill_way;
    logic [1:0] plru_victim;
    logic       touch;
    logic [1:0] touch_way;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        cache_way #(.way_id(w)) way_i (
            .clk(clk), .rst(rst), .cmd(cmd),
            .hit(hit_vec[w]), .valid(valid_vec[w]), .dirty(dirty_vec[w]),
            .tag_out(tag_arr[w]), .line_out(line_arr[w]), .rdata(rdata_arr[w])
        );
    end

    // at most one way hits, so a plain encoder is enough
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w]) hit_way = 2'(w);
        end
    end

    assign hit = |hit_vec;

    plru_tree plru_i (
        .clk(clk), .rst(rst), .index(cmd.addr[offset_w +: index_w]),
        .touch(touch), .touch_way(touch_way), .victim(plru_victim)
    );

    cache_ctrl ctrl_i (
        .clk(clk), .rst(rst), .req(req), .req_data(req_data),
        .hit(hit), .hit_way(hit_way), .hit_rdata(rdata_arr[hit_way]),
        .valid_vec(valid_vec), .victim_dirty(dirty_vec[fill_way]),
        .victim_tag(tag_arr[fill_way]), .victim_line(line_arr[fill_way]),
        .plru_victim(plru_victim), .mem_ack(mem_ack), .mem_rline(mem_rline),
        .cmd(cmd), .touch(touch), .touch_way(touch_way), .fill_way(fill_way),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .done(done), .busy(busy), .rdata(rdata)
    );

endmodule

// File: verification/tb_memory.sv
// backing memory model; unwritten lines read an address pattern and ack takes 1 to 6 cycles
`timescale 1ns/100ps

module tb_memory import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_req,
    input  mem_req_t          mem_cmd,
    output logic              mem_ack,
    output logic [line_w-1:0] mem_rline
);

    logic [line_w-1:0] image [logic [addr_w-1:0]];  // golden copy keyed by line address
    integer            seed;
    int                delay;

    // each word is its own address scrambled by a constant
    function automatic logic [line_w-1:0] fill_line(input logic [addr_w-1:0] line_addr);
        logic [line_w-1:0] l;
        for (int w = 0; w < line_bytes / 4; w++) begin
            l[w*32 +: 32] = (line_addr + 32'(w * 4)) ^ 32'h3c5a_96e1;
        end
        return l;
    endfunction

    initial begin
        seed      = 75518;
        mem_ack   = 1'b0;
        mem_rline = '0;
        forever begin
            @(posedge clk);
            if (rst && mem_req) begin
                delay = 1 + int'($unsigned($random(seed)) % 6);
                repeat (delay - 1) @(posedge clk);
                if (mem_cmd.we) begin
                    image[mem_cmd.addr] = mem_cmd.wline;
                end else if (image.exists(mem_cmd.addr)) begin
                    mem_rline <= image[mem_cmd.addr];
                end else begin
                    mem_rline <= fill_line(mem_cmd.addr);
                end
                mem_ack <= 1'b1;
                @(posedge clk);
                mem_ack <= 1'b0;  // mem_req drops after this edge
            end
        end
    end

endmodule

// File: verification/tb_dcache.sv
// random load/store test against a byte model; runs a fixed 2000 accesses from one seed
`timescale 1ns/100ps

module tb_dcache import cache_pkg::*; ();

    localparam int num_accesses    = 2000;
    localparam int done_limit      = 200;
    localparam int watchdog_cycles = num_accesses * 40 + 16;

    logic              clk;
    logic              rst;
    logic              req;
    cpu_req_t          req_data;
    logic              done;
    logic              busy;
    logic [31:0]       rdata;
    logic              mem_req;
    mem_req_t          mem_cmd;
    logic              mem_ack;
    logic [line_w-1:0] mem_rline;

    logic [7:0]        model [logic [addr_w-1:0]];   // processor-visible bytes
    bit                written [logic [addr_w-1:0]]; // lines written since refill
    integer            seed;
    logic [31:0]       cur_addr;
    bit                started;
    bit                aborted;
    int                data_errors;
    int                mem_errors;
    int                timing_errors;

    dcache_top dcache_top_i (
        .clk(clk), .rst(rst), .req(req), .req_data(req_data),
        .done(done), .busy(busy), .rdata(rdata),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack), .mem_rline(mem_rline)
    );

    tb_memory memory_i (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_cmd(mem_cmd),
        .mem_ack(mem_ack), .mem_rline(mem_rline)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // same pattern as the memory model for bytes never written
    function automatic logic [7:0] model_byte(input logic [31:0] a);
        logic [31:0] word;
        word = {a[31:2], 2'b00} ^ 32'h3c5a_96e1;
        if (model.exists(a)) return model[a];
        return word[8*a[1:0] +: 8];
    endfunction

    function automatic logic [line_w-1:0] model_line(input logic [31:0] line_addr);
        logic [line_w-1:0] l;
        for (int b = 0; b < line_bytes; b++) l[8*b +: 8] = model_byte(line_addr + 32'(b));
        return l;
    endfunction

    function automatic int size_bytes(input size_t sz);
        case (sz)
            sz_byte: return 1;
            sz_half: return 2;
            default: return 4;
        endcase
    endfunction

    // one access from strobe to done; repeat checks the hit timing too
    task automatic run_access(input logic [31:0] a, input logic [31:0] wd, input size_t sz,
                              input logic we, input bit is_repeat);
        logic [31:0] expected;
        int          cycles;
        bit          mem_seen;
        bit          busy_gap;
        expected = '0;
        for (int b = 0; b < size_bytes(sz); b++) expected[8*b +: 8] = model_byte(a + 32'(b));
        @(posedge clk);
        req      <= 1'b1;
        req_data <= '{addr: a, wdata: wd, size: sz, we: we};
        cur_addr = a;
        started  = 1'b1;
        @(posedge clk);
        req      <= 1'b0;
        cycles   = 0;
        mem_seen = 1'b0;
        busy_gap = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            if (mem_req) mem_seen = 1'b1;
            if (!busy) busy_gap = 1'b1;   // busy must cover the whole access
        end while (!done && cycles < done_limit);
        assert (done) else begin
            timing_errors++;
            $display("no done within %0d cycles for access to %h at %0t", done_limit, a, $time);
            aborted = 1'b1;
        end
        if (aborted) return;
        assert (!busy_gap) else begin
            timing_errors++;
            $display("busy went low before done for access to %h at %0t", a, $time);
        end
        if (!we) begin
            assert (rdata == expected) else begin
                data_errors++;
                $display("[ERROR] %0t rdata: got %h expected %h (addr %h)",
                         $time, rdata, expected, a);
            end
        end
        if (is_repeat) begin
            assert (!mem_seen) else begin
                timing_errors++;
                $display("repeated access to %h raised mem_req at %0t", a, $time);
            end
            assert (cycles == 2) else begin
                timing_errors++;
                $display("[ERROR] %0t done latency: got %0d expected %0d", $time, cycles, 2);
            end
        end
        if (we) begin
            for (int b = 0; b < size_bytes(sz); b++) model[a + 32'(b)] = wd[8*b +: 8];
            written[{a[31:4], 4'h0}] = 1'b1;
        end
    endtask

    // memory port transfers checked in the ack cycle
    always @(posedge clk) begin
        logic [line_w-1:0] exp_line;
        if (rst && mem_req && mem_ack) begin
            assert (mem_cmd.addr[3:0] == 4'h0) else begin
                mem_errors++;
                $display("[ERROR] %0t mem_cmd.addr: got %h expected %h",
                         $time, mem_cmd.addr, {mem_cmd.addr[31:4], 4'h0});
            end
            if (mem_cmd.we) begin
                exp_line = model_line(mem_cmd.addr);
                assert (written.exists(mem_cmd.addr)) else begin
                    mem_errors++;
                    $display("line %h written back without a write since its refill at %0t",
                             mem_cmd.addr, $time);
                end
                assert (mem_cmd.wline == exp_line) else begin
                    mem_errors++;
                    $display("[ERROR] %0t mem_cmd.wline: got %h expected %h",
                             $time, mem_cmd.wline, exp_line);
                end
            end else begin
                assert (mem_cmd.addr == {cur_addr[31:4], 4'h0}) else begin
                    mem_errors++;
                    $display("[ERROR] %0t mem_cmd.addr: got %h expected %h",
                             $time, mem_cmd.addr, {cur_addr[31:4], 4'h0});
                end
            end
            written.delete(mem_cmd.addr);
        end
    end

    // quiet port from reset to the first request
    always @(posedge clk) begin
        if (!started) begin
            assert (!done && !busy && !mem_req) else begin
                timing_errors++;
                $display("done, busy or mem_req high before the first request at %0t", $time);
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] wd;
        logic [3:0]  off;
        size_t       sz;
        logic        we;
        seed     = 75518;
        rst      = 1'b0;
        req      = 1'b0;
        req_data = '0;
        started  = 1'b0;
        aborted  = 1'b0;
        cur_addr = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        for (int n = 0; n < num_accesses && !aborted; n++) begin
            sz  = size_t'($unsigned($random(seed)) % 3);
            off = 4'($unsigned($random(seed)));
            if (sz == sz_word) off[1:0] = 2'b00;
            if (sz == sz_half) off[0] = 1'b0;
            // 8 tags over 4 sets is twice the associativity
            a = {22'h0a000 + 22'($unsigned($random(seed)) % 8 * 37),
                 6'(($unsigned($random(seed)) % 4) * 16 + 5), off};
            wd = $random(seed);
            we = 1'($random(seed));
            run_access(a, wd, sz, we, 1'b0);
            if (!aborted && ($unsigned($random(seed)) % 4) == 0) begin
                run_access(a, 32'h0, sz, 1'b0, 1'b1);
            end
        end
        $display("errors: %0d read data, %0d memory port, %0d timing",
                 data_errors, mem_errors, timing_errors);
        if (data_errors + mem_errors + timing_errors == 0 && !aborted) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/plru_tree.sv
verilog/cache_ctrl.sv
verilog/dcache_top.sv
verification/tb_memory.sv
verification/tb_dcache.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dcache
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
